//--- include/pinball_config.svh
`ifndef PINBALL_CONFIG_SVH
`define PINBALL_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ball placement.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define BALL_INIT_X 300 // top-left pixel at start and restart.
`define BALL_INIT_Y 40

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// motion.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define FIXED_POINT_MULTIPLIER 64 // fixed-point units per pixel.
`define GRAVITY 8 // added to vy once per frame.

// bound on |vx| and |vy| whenever a frame is applied.
`define SPEED_LIMIT 4096

`endif

//--- source/pinball_pkg.sv
package pinball_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// motion events.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [2:0] {
		evNone    = 3'd0,
		evFrame   = 3'd1,
		evWall    = 3'd2, // frame wall or obstacle.
		evSpring  = 3'd3,
		evBumper  = 3'd4,
		evFlipper = 3'd5,
		evRestart = 3'd6
	} eventKind_t;

	// side of the ball that was hit.
	typedef struct packed {
		logic left;
		logic top;
		logic right;
		logic bottom;
	} edgeMask_t;

	typedef struct packed {
		eventKind_t         kind;
		edgeMask_t          edges;
		logic signed [31:0] flipperSpeedX;
		logic signed [31:0] springSpeedY;
	} motionEvent_t;

	// fixed-point units per frame.
	typedef struct packed {
		logic signed [31:0] vx;
		logic signed [31:0] vy;
	} ballVelocity_t;

endpackage

//--- source/collisionDecoder.sv
`timescale 1ns/1ps

module collisionDecoder(
	input  logic                      clk,
	input  logic                      resetN,
	input  logic                      startOfFrame,
	input  logic                      wallHit,
	input  logic                      obstacleHit,
	input  logic                      springHit,
	input  logic                      bumperHit,
	input  logic                      flipperHit,
	input  logic                      pause,
	input  logic                      restartLevel,
	input  pinball_pkg::edgeMask_t    hitEdges,
	input  int                        flipperSpeedX,
	input  int                        springSpeedY,
	output pinball_pkg::motionEvent_t motionEvent
);
	import pinball_pkg::*;

	eventKind_t         nextKind;
	eventKind_t         kindQ;
	edgeMask_t          edgesQ;
	logic signed [31:0] flipperSpeedQ;
	logic signed [31:0] springSpeedQ;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// priority select.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		nextKind = evNone;
		if (restartLevel)
			nextKind = evRestart; // wins even while paused.
		else if (pause)
			nextKind = evNone;
		else if (startOfFrame)
			nextKind = evFrame; // same-cycle collisions are lost.
		else if (wallHit || obstacleHit)
			nextKind = evWall;
		else if (springHit)
			nextKind = evSpring;
		else if (bumperHit)
			nextKind = evBumper;
		else if (flipperHit)
			nextKind = evFlipper;
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			kindQ <= evNone;
		else
			kindQ <= nextKind;
	end

	// payload rides along with the kind.
	always_ff @(posedge clk) begin
		edgesQ        <= hitEdges;
		flipperSpeedQ <= flipperSpeedX;
		springSpeedQ  <= springSpeedY;
	end

	assign motionEvent = '{kind: kindQ, edges: edgesQ,
		flipperSpeedX: flipperSpeedQ, springSpeedY: springSpeedQ};

	// no event leaves the decoder after reset or a paused cycle.
	assert property (@(posedge clk)
		(!resetN || (pause && !restartLevel)) |=> (motionEvent.kind == evNone));

endmodule

//--- source/velocityUpdater.sv
`timescale 1ns/1ps
`include "pinball_config.svh"

module velocityUpdater(
	input  logic                       clk,
	input  logic                       resetN,
	input  pinball_pkg::motionEvent_t  motionEvent,
	output pinball_pkg::ballVelocity_t velocity
);
	import pinball_pkg::*;

	ballVelocity_t nextVelocity;
	edgeMask_t     edges;
	logic          movingUp;
	logic          movingDown;
	logic          movingLeft;
	logic          movingRight;

	assign edges       = motionEvent.edges;
	assign movingUp    = velocity.vy < 0;
	assign movingDown  = velocity.vy > 0;
	assign movingLeft  = velocity.vx < 0;
	assign movingRight = velocity.vx > 0;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// event execution.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		nextVelocity = velocity;
		case (motionEvent.kind)
			evRestart: begin
				nextVelocity = '0;
			end
			evFrame: begin
				nextVelocity.vy = velocity.vy + `GRAVITY;
			end
			evWall: begin
				// reflect only when the hit side faces the motion.
				if ((edges.top && movingUp) || (edges.bottom && movingDown))
					nextVelocity.vy = -velocity.vy;
				if ((edges.left && movingLeft) || (edges.right && movingRight))
					nextVelocity.vx = -velocity.vx;
			end
			evSpring: begin
				if (edges.bottom) begin
					if (motionEvent.springSpeedY < 0)
						nextVelocity.vy = velocity.vy + motionEvent.springSpeedY; // launch.
					else
						nextVelocity.vy = -velocity.vy;
				end
			end
			evBumper: begin
				if (movingUp) begin
					nextVelocity.vy = -velocity.vy;
					nextVelocity.vx = velocity.vy; // sideways kick from old vy.
				end
			end
			evFlipper: begin
				if (edges.bottom && movingDown) begin
					nextVelocity.vy = -velocity.vy;
					nextVelocity.vx = velocity.vx + motionEvent.flipperSpeedX;
				end
			end
			default: begin
				nextVelocity = velocity;
			end
		endcase
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			velocity <= '0;
		else
			velocity <= nextVelocity;
	end

	// an empty event leaves the ball's speed alone.
	assert property (@(posedge clk) disable iff (!resetN)
		(motionEvent.kind == evNone) |=> $stable(velocity));

endmodule

//--- source/positionIntegrator.sv
`timescale 1ns/1ps
`include "pinball_config.svh"

module positionIntegrator(
	input  logic                       clk,
	input  logic                       resetN,
	input  pinball_pkg::motionEvent_t  motionEvent,
	input  pinball_pkg::ballVelocity_t velocity,
	output logic signed [10:0]         topLeftX,
	output logic signed [10:0]         topLeftY
);
	import pinball_pkg::*;

	localparam int initXFixed = `BALL_INIT_X * `FIXED_POINT_MULTIPLIER;
	localparam int initYFixed = `BALL_INIT_Y * `FIXED_POINT_MULTIPLIER;

	logic signed [31:0] posX;
	logic signed [31:0] posY;
	logic signed [31:0] pixelX;
	logic signed [31:0] pixelY;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// fixed-point position.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			posX <= initXFixed;
			posY <= initYFixed;
		end else begin
			case (motionEvent.kind)
				evRestart: begin
					posX <= initXFixed;
					posY <= initYFixed;
				end
				evFrame: begin
					posX <= posX + velocity.vx; // velocity before this edge's update.
					posY <= posY + velocity.vy;
				end
				default: begin
					posX <= posX;
					posY <= posY;
				end
			endcase
		end
	end

	// signed division truncates toward zero.
	assign pixelX   = posX / `FIXED_POINT_MULTIPLIER;
	assign pixelY   = posY / `FIXED_POINT_MULTIPLIER;
	assign topLeftX = pixelX[10:0];
	assign topLeftY = pixelY[10:0];

	// speeds stay bounded whenever they move the ball.
	assert property (@(posedge clk) disable iff (!resetN)
		(motionEvent.kind == evFrame) |->
			(velocity.vx <= `SPEED_LIMIT) && (velocity.vx >= -`SPEED_LIMIT) &&
			(velocity.vy <= `SPEED_LIMIT) && (velocity.vy >= -`SPEED_LIMIT));

endmodule

//--- source/ballMotion.sv
`timescale 1ns/1ps

module ballMotion(
	input  logic                   clk,
	input  logic                   resetN,
	input  logic                   startOfFrame,
	input  logic                   wallHit,
	input  logic                   obstacleHit,
	input  logic                   springHit,
	input  logic                   bumperHit,
	input  logic                   flipperHit,
	input  pinball_pkg::edgeMask_t hitEdges,
	input  int                     flipperSpeedX,
	input  int                     springSpeedY,
	input  logic                   pause,
	input  logic                   restartLevel,
	output logic signed [10:0]     topLeftX,
	output logic signed [10:0]     topLeftY
);
	import pinball_pkg::*;

	motionEvent_t  motionEvent;
	ballVelocity_t velocity;

	// decode.
	collisionDecoder decoder_i(
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.wallHit(wallHit),
		.obstacleHit(obstacleHit),
		.springHit(springHit),
		.bumperHit(bumperHit),
		.flipperHit(flipperHit),
		.pause(pause),
		.restartLevel(restartLevel),
		.hitEdges(hitEdges),
		.flipperSpeedX(flipperSpeedX),
		.springSpeedY(springSpeedY),
		.motionEvent(motionEvent)
	);

	// execute.
	velocityUpdater updater_i(
		.clk(clk),
		.resetN(resetN),
		.motionEvent(motionEvent),
		.velocity(velocity)
	);

	// result.
	positionIntegrator integrator_i(
		.clk(clk),
		.resetN(resetN),
		.motionEvent(motionEvent),
		.velocity(velocity),
		.topLeftX(topLeftX),
		.topLeftY(topLeftY)
	);

endmodule

//--- test/clockGen.sv
`timescale 1ns/1ps

module clockGen(
	output logic clk,
	output logic resetN
);
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period.
	end

	initial begin
		resetN = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		#1 resetN = 1'b1; // released clear of both clock edges.
	end

endmodule

//--- test/ballMotionTb.sv
`timescale 1ns/1ps
`include "pinball_config.svh"

module ballMotionTb;
	import pinball_pkg::*;

	localparam int clockPeriod    = 4;
	localparam int randomCycles   = 2000;
	localparam int directedCycles = 200;
	localparam int initXFixed     = `BALL_INIT_X * `FIXED_POINT_MULTIPLIER;
	localparam int initYFixed     = `BALL_INIT_Y * `FIXED_POINT_MULTIPLIER;

	// strobe bits from restart down to flipper.
	localparam logic [7:0] sRestart  = 8'h80;
	localparam logic [7:0] sPause    = 8'h40;
	localparam logic [7:0] sFrame    = 8'h20;
	localparam logic [7:0] sWall     = 8'h10;
	localparam logic [7:0] sObstacle = 8'h08;
	localparam logic [7:0] sSpring   = 8'h04;
	localparam logic [7:0] sBumper   = 8'h02;
	localparam logic [7:0] sFlipper  = 8'h01;
	localparam logic [3:0] eLeft     = 4'b1000;
	localparam logic [3:0] eTop      = 4'b0100;
	localparam logic [3:0] eRight    = 4'b0010;
	localparam logic [3:0] eBottom   = 4'b0001;

	logic               clk;
	logic               resetN;
	logic [7:0]         strobes;
	edgeMask_t          hitEdges;
	int                 flipperSpeedX;
	int                 springSpeedY;
	logic signed [10:0] topLeftX;
	logic signed [10:0] topLeftY;

	eventKind_t         modelKind;
	edgeMask_t          modelEdges;
	int                 modelFlip;
	int                 modelSpring;
	ballVelocity_t      modelVel;
	int                 modelPosX;
	int                 modelPosY;
	logic signed [10:0] expX;
	logic signed [10:0] expY;
	logic [31:0]        lfsrState;
	int                 monitorChecks;
	int                 monitorErrors;
	int                 directChecks;
	int                 directErrors;
	int                 testErrorBase;
	int                 testCount;
	int                 heldX;
	int                 heldY;

	clockGen clockGen_i(.clk(clk), .resetN(resetN));

	ballMotion dut_i(
		.clk(clk), .resetN(resetN),
		.startOfFrame(strobes[5]), .wallHit(strobes[4]), .obstacleHit(strobes[3]),
		.springHit(strobes[2]), .bumperHit(strobes[1]), .flipperHit(strobes[0]),
		.hitEdges(hitEdges), .flipperSpeedX(flipperSpeedX), .springSpeedY(springSpeedY),
		.pause(strobes[6]), .restartLevel(strobes[7]),
		.topLeftX(topLeftX), .topLeftY(topLeftY)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// random source.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic int takeBits(input int n);
		int value;
		value = 0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState); // one step per bit.
			value = (value << 1) | int'(lfsrState[0]);
		end
		return value;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic eventKind_t decodeKind(input logic [7:0] s);
		eventKind_t kind;
		kind = evNone;
		if (s[0]) kind = evFlipper; // lowest priority first.
		if (s[1]) kind = evBumper;
		if (s[2]) kind = evSpring;
		if (s[4] || s[3]) kind = evWall;
		if (s[5]) kind = evFrame;
		if (s[6]) kind = evNone;
		if (s[7]) kind = evRestart;
		return kind;
	endfunction

	function automatic ballVelocity_t expectedVelocity(input eventKind_t kind,
			input edgeMask_t e, input int fs, input int ss, input ballVelocity_t v);
		ballVelocity_t n;
		n = v;
		if (kind == evRestart)
			n = '0;
		else if (kind == evFrame)
			n.vy = v.vy + `GRAVITY;
		else if (kind == evWall) begin
			if ((e.top && v.vy < 0) || (e.bottom && v.vy > 0))
				n.vy = -v.vy;
			if ((e.left && v.vx < 0) || (e.right && v.vx > 0))
				n.vx = -v.vx;
		end else if (kind == evSpring && e.bottom)
			n.vy = (ss < 0) ? v.vy + ss : -v.vy;
		else if (kind == evBumper && v.vy < 0) begin
			n.vy = -v.vy;
			n.vx = v.vy;
		end else if (kind == evFlipper && e.bottom && v.vy > 0) begin
			n.vy = -v.vy;
			n.vx = v.vx + fs;
		end
		return n;
	endfunction

	function automatic logic signed [10:0] toPixel(input int fixedPos);
		int whole;
		if (fixedPos < 0)
			whole = -((-fixedPos) / `FIXED_POINT_MULTIPLIER); // toward zero.
		else
			whole = fixedPos / `FIXED_POINT_MULTIPLIER;
		return whole[10:0];
	endfunction

	always @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			modelKind <= evNone;
			modelVel  <= '0;
			modelPosX <= initXFixed;
			modelPosY <= initYFixed;
		end else begin
			modelVel <= expectedVelocity(modelKind, modelEdges, modelFlip, modelSpring, modelVel);
			if (modelKind == evRestart) begin
				modelPosX <= initXFixed;
				modelPosY <= initYFixed;
			end else if (modelKind == evFrame) begin
				modelPosX <= modelPosX + modelVel.vx; // old velocity moves the ball.
				modelPosY <= modelPosY + modelVel.vy;
			end
			modelKind <= decodeKind(strobes);
		end
		modelEdges  <= hitEdges;
		modelFlip   <= flipperSpeedX;
		modelSpring <= springSpeedY;
	end

	// outputs settle between edges.
	always @(negedge clk) begin
		if (resetN) begin
			expX = toPixel(modelPosX);
			expY = toPixel(modelPosY);
			monitorChecks = monitorChecks + 1;
			if (topLeftX !== expX) begin
				$display("Mismatch topLeftX: expected 0x%h, actual 0x%h", expX, topLeftX);
				monitorErrors = monitorErrors + 1;
			end
			if (topLeftY !== expY) begin
				$display("Mismatch topLeftY: expected 0x%h, actual 0x%h", expY, topLeftY);
				monitorErrors = monitorErrors + 1;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic drive(input logic [7:0] s, input logic [3:0] e, input int fs, input int ss);
		@(posedge clk);
		strobes       <= s;
		hitEdges      <= e;
		flipperSpeedX <= fs;
		springSpeedY  <= ss;
	endtask

	task automatic idle(input int n);
		repeat (n) drive(8'h00, 4'h0, 0, 0);
	endtask

	task automatic frames(input int n);
		repeat (n) begin
			drive(sFrame, 4'h0, 0, 0);
			idle(1);
		end
	endtask

	task automatic checkPixels(input int wantX, input int wantY);
		@(negedge clk);
		directChecks = directChecks + 1;
		if (topLeftX !== wantX[10:0]) begin
			$display("Mismatch topLeftX: expected 0x%h, actual 0x%h", wantX[10:0], topLeftX);
			directErrors = directErrors + 1;
		end
		if (topLeftY !== wantY[10:0]) begin
			$display("Mismatch topLeftY: expected 0x%h, actual 0x%h", wantY[10:0], topLeftY);
			directErrors = directErrors + 1;
		end
	endtask

	task automatic finishTest(input string name);
		idle(3); // drain the two-stage pipe.
		testCount = testCount + 1;
		$display("test %s finished, errors %0d", name,
			monitorErrors + directErrors - testErrorBase);
		testErrorBase = monitorErrors + directErrors;
	endtask

	task automatic randomRun(input int cycles);
		logic [7:0] s;
		int         e;
		int         fs;
		int         ss;
		for (int c = 0; c < cycles; c++) begin
			s = 8'h00;
			s[7] = (c % 64 == 63); // periodic restart keeps speeds small.
			s[6] = (takeBits(4) == 0);
			s[5] = (takeBits(2) == 0);
			for (int b = 0; b < 5; b++)
				s[b] = (takeBits(3) == 0);
			e = takeBits(4);
			fs = takeBits(7) - 64;
			ss = takeBits(7) - 64;
			drive(s, e[3:0], fs, ss);
		end
	endtask

	initial begin
		strobes       <= 8'h00;
		hitEdges      <= 4'h0;
		flipperSpeedX <= 0;
		springSpeedY  <= 0;
		lfsrState = 32'h63a0_314d;
		@(posedge resetN);

		frames(12); // from rest, y grows by the running sum.
		idle(1);
		checkPixels(`BALL_INIT_X, (initYFixed + `GRAVITY * 12 * 11 / 2) / `FIXED_POINT_MULTIPLIER);
		finishTest("freeFall");

		drive(sWall, eTop, 0, 0); // top does not face a falling ball.
		drive(sWall, eBottom, 0, 0);
		drive(sObstacle, eBottom, 0, 0);
		frames(3);
		drive(sObstacle, eTop | eRight, 0, 0);
		frames(2);
		drive(sFlipper, eBottom, 20, 0);
		drive(sWall, eLeft, 0, 0);
		drive(sWall, eRight, 0, 0);
		drive(sObstacle, eLeft | eBottom, 0, 0);
		frames(3);
		finishTest("wallBounce");

		drive(sRestart, 4'h0, 0, 0);
		frames(5);
		drive(sFlipper, eBottom, 24, 0);
		frames(1);
		drive(sBumper, 4'h0, 0, 0);
		drive(sSpring, eBottom, 0, -30); // launch.
		drive(sSpring, eBottom, 0, 20);
		drive(sWall | sSpring | sFlipper, eBottom | eTop, 10, -10);
		drive(sFrame | sBumper, 4'h0, 0, 0); // bumper is lost.
		drive(sSpring | sBumper, eBottom, 0, -12);
		drive(sFlipper, eTop, 30, 0);
		frames(4);
		finishTest("collisions");

		frames(3);
		idle(2);
		@(negedge clk);
		heldX = toPixel(modelPosX);
		heldY = toPixel(modelPosY);
		repeat (8) drive(sPause | sFrame | sWall | sBumper, eBottom | eTop, 16, -16);
		idle(2);
		checkPixels(heldX, heldY);
		frames(4);
		finishTest("pause");

		frames(4);
		drive(sRestart | sPause | sFrame, 4'h0, 0, 0);
		idle(2);
		checkPixels(`BALL_INIT_X, `BALL_INIT_Y);
		frames(3);
		finishTest("restart");

		randomRun(randomCycles);
		finishTest("random");

		$display("tests %0d, checks %0d, errors %0d", testCount,
			monitorChecks + directChecks, monitorErrors + directErrors);
		if (monitorErrors + directErrors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	initial begin
		#((randomCycles + directedCycles) * clockPeriod + 1000);
		$display("Timeout: the tests did not finish within the expected number of cycles");
		$display("Verification failed");
		$finish;
	end

endmodule

//--- pinball.f
+incdir+include
source/pinball_pkg.sv
source/collisionDecoder.sv
source/velocityUpdater.sv
source/positionIntegrator.sv
source/ballMotion.sv
test/clockGen.sv
test/ballMotionTb.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -j 0 --top-module ballMotionTb -f pinball.f \
	&& ./obj_dir/VballMotionTb | tee /dev/stderr | grep -x "Verification passed" > /dev/null \
	&& echo "simulation ok" \
	|| { echo "simulation FAILED"; exit 1; }
